/* fdc_host_regs.sv */
`timescale 1ns/1ps

module fdc_host_regs (
	input  logic                CLK_MASTER,
	input  logic                rst_n,
	input  logic [7:0]          pmd_in,
	input  logic                pmalh,
	input  logic                pmall,
	input  logic                pmrd,
	input  logic                pmwr,
	input  logic [7:0]          status1,
	input  logic [7:0]          status2,
	input  fdc_pkg::sram_addr_t sram_addr,
	input  logic [7:0]          sram_dq_in,
	input  logic [7:0]          index_hi,
	input  logic [7:0]          index_lo,
	output logic [7:0]          pmd_out,
	output logic                pmd_oe,
	output fdc_pkg::fd_ctl_t    fd_ctl,
	output logic [7:0]          step_rate,
	output logic                step_cmd_wr,
	output logic                fifo_push,
	output fdc_pkg::bus_wr_t    bus_wr,
	output fdc_pkg::host_byte_u wr_data,
	output logic                index_hi_rd
);
	import fdc_pkg::*;

	logic       pmwr_s, pmwr_d;		// Strobe stage and edge history
	logic       pmrd_s, pmrd_d;
	logic       wr_pulse, rd_pulse, rd_fall;
	logic [7:0] addr_hi, addr_lo;
	logic       page0;
	logic       sel_sram;
	drive_ctl_t drive_q;
	logic [7:0] scratch;
	logic [7:0] dq_lat;				// SRAM byte held for the host

	//////////////////////////////////////////////////////////////////////
	// Strobes and address latch

	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			pmwr_s  <= 1'b0;
			pmwr_d  <= 1'b0;
			pmrd_s  <= 1'b0;
			pmrd_d  <= 1'b0;
			addr_hi <= 8'h00;
			addr_lo <= 8'h00;
		end else begin
			pmwr_s <= pmwr;
			pmwr_d <= pmwr_s;
			pmrd_s <= pmrd;
			pmrd_d <= pmrd_s;
			if (pmalh) addr_hi <= pmd_in;	// Level loads, any cycle
			if (pmall) addr_lo <= pmd_in;
		end
	end

	assign wr_pulse = pmwr_s && !pmwr_d;	// Cycle after pmwr rises
	assign rd_pulse = pmrd_s && !pmrd_d;
	assign rd_fall  = pmrd_d && !pmrd_s;	// Cycle after pmrd falls

	assign page0    = (addr_hi == 8'h00);	// Whole map sits in page 0
	assign sel_sram = page0 && (addr_lo == REG_SRAM_DATA);
	assign wr_data  = pmd_in;

	// Decoded strobes for the other blocks
	assign fifo_push             = wr_pulse && sel_sram;
	assign step_cmd_wr           = wr_pulse && page0 && (addr_lo == REG_STEP_CMD);
	assign bus_wr.addr_low       = wr_pulse && page0 && (addr_lo == REG_ADDR_LOW);
	assign bus_wr.addr_high      = wr_pulse && page0 && (addr_lo == REG_ADDR_HIGH);
	assign bus_wr.addr_upper     = wr_pulse && page0 && (addr_lo == REG_ADDR_UPPER);
	assign bus_wr.data_read_done = rd_fall && sel_sram;	// Advance after the host read
	assign index_hi_rd           = rd_pulse && page0 && (addr_lo == REG_INDEX_HI);

	//////////////////////////////////////////////////////////////////////
	// Local registers

	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			drive_q   <= '0;			// All drive outputs inactive
			step_rate <= 8'h00;
			scratch   <= 8'h00;
		end else if (wr_pulse && page0) begin
			case (addr_lo)
				REG_DRIVE_CTL: drive_q   <= wr_data.drive;
				REG_STEP_RATE: step_rate <= wr_data.raw;
				REG_SCRATCH:   scratch   <= wr_data.raw;
				default: ;
			endcase
		end
	end

	// Track SRAM data until the host raises pmrd
	always_ff @(posedge CLK_MASTER) begin
		if (!pmrd && sel_sram) dq_lat <= sram_dq_in;
	end

	// Drive outputs are active low
	assign fd_ctl.side_n   = ~drive_q.side;
	assign fd_ctl.motor_n  = ~drive_q.motor;
	assign fd_ctl.drvsel_n = ~drive_q.drvsel;
	assign fd_ctl.inuse_n  = ~drive_q.in_use;
	assign fd_ctl.dens_n   = ~drive_q.density;

	//////////////////////////////////////////////////////////////////////
	// Readback

	assign pmd_oe = pmrd;

	always_comb begin
		pmd_out = 8'h00;				// Unused addresses
		if (page0) begin
			case (addr_lo)
				REG_ADDR_LOW:    pmd_out = sram_addr[7:0];
				REG_ADDR_HIGH:   pmd_out = sram_addr[15:8];
				REG_ADDR_UPPER:  pmd_out = {{(24-SRAM_AW){1'b0}}, sram_addr[SRAM_AW-1:16]};
				REG_SRAM_DATA:   pmd_out = dq_lat;
				REG_MCO_TYPE_LO: pmd_out = MCO_TYPE[7:0];
				REG_MCO_TYPE_HI: pmd_out = MCO_TYPE[15:8];
				REG_MCO_VER_LO:  pmd_out = MCO_VERSION[7:0];
				REG_MCO_VER_HI:  pmd_out = MCO_VERSION[15:8];
				REG_STATUS1:     pmd_out = status1;
				REG_STATUS2:     pmd_out = status2;
				REG_SCRATCH:     pmd_out = scratch;
				REG_SCRATCH_INV: pmd_out = ~scratch;	// Bus stuck-bit check
				REG_FIXED_55:    pmd_out = 8'h55;
				REG_FIXED_AA:    pmd_out = 8'hAA;
				REG_INDEX_HI:    pmd_out = index_hi;
				REG_INDEX_LO:    pmd_out = index_lo;
				REG_STEP_RATE:   pmd_out = step_rate;
				default: ;
			endcase
		end
	end

	// FIFO and stepper never see the same write
	a_one_target: assert property (@(posedge CLK_MASTER) disable iff (!rst_n)
		!(fifo_push && step_cmd_wr));

endmodule

/* fdc_index_timer.sv */
`timescale 1ns/1ps

module fdc_index_timer (
	input  logic       CLK_MASTER,
	input  logic       rst_n,
	input  logic       index_in,
	input  logic       hi_read,
	output logic [7:0] index_hi,
	output logic [7:0] index_lo,
	output logic       new_meas
);
	import fdc_pkg::*;

	logic [1:0]  idx_sync;			// Two stage synchroniser
	logic        idx_d;
	logic        idx_rise;
	logic [15:0] tick_cnt;
	logic        tick;
	logic [15:0] period;			// Running count of 10 us ticks
	logic [15:0] period_lat;		// Last full revolution
	logic [7:0]  lo_q;

	assign idx_rise = idx_sync[1] && !idx_d;
	assign tick     = (tick_cnt == 16'(INDEX_TICK_DIV - 1));

	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			idx_sync   <= 2'b00;
			idx_d      <= 1'b0;
			tick_cnt   <= 16'd0;
			period     <= 16'd0;
			period_lat <= 16'd0;
			lo_q       <= 8'h00;
			new_meas   <= 1'b0;
		end else begin
			idx_sync <= {idx_sync[0], index_in};
			idx_d    <= idx_sync[1];
			tick_cnt <= tick ? 16'd0 : tick_cnt + 16'd1;

			if (idx_rise) begin
				period_lat <= period;		// Save and restart
				period     <= 16'd0;
			end else if (tick) begin
				period <= period + 16'd1;
			end

			// Freeze low byte on high byte read so the pair stays coherent
			if (hi_read) lo_q <= period_lat[7:0];

			if (hi_read)       new_meas <= 1'b0;	// Read wins over edge
			else if (idx_rise) new_meas <= 1'b1;
		end
	end

	assign index_hi = period_lat[15:8];
	assign index_lo = lo_q;

endmodule

/* fdc_pkg.sv */
package fdc_pkg;

	//////////////////////////////////////////////////////////////////////
	// Register map, page 0 only

	localparam logic [7:0] REG_ADDR_LOW     = 8'h00;	// SRAM address bits 7:0
	localparam logic [7:0] REG_ADDR_HIGH    = 8'h01;	// SRAM address bits 15:8
	localparam logic [7:0] REG_ADDR_UPPER   = 8'h02;	// SRAM address bits 18:16
	localparam logic [7:0] REG_SRAM_DATA    = 8'h03;	// FIFO push / SRAM data read
	localparam logic [7:0] REG_DRIVE_CTL    = 8'h04;	// Write only
	localparam logic [7:0] REG_MCO_TYPE_LO  = 8'h04;	// Read side of 04
	localparam logic [7:0] REG_MCO_TYPE_HI  = 8'h05;
	localparam logic [7:0] REG_MCO_VER_LO   = 8'h06;
	localparam logic [7:0] REG_MCO_VER_HI   = 8'h07;
	localparam logic [7:0] REG_STATUS1      = 8'h0E;
	localparam logic [7:0] REG_STATUS2      = 8'h0F;
	localparam logic [7:0] REG_SCRATCH      = 8'h30;
	localparam logic [7:0] REG_SCRATCH_INV  = 8'h31;
	localparam logic [7:0] REG_FIXED_55     = 8'h32;
	localparam logic [7:0] REG_FIXED_AA     = 8'h33;
	localparam logic [7:0] REG_INDEX_HI     = 8'h40;	// Read this one first
	localparam logic [7:0] REG_INDEX_LO     = 8'h41;
	localparam logic [7:0] REG_STEP_RATE    = 8'hF0;
	localparam logic [7:0] REG_STEP_CMD     = 8'hFF;

	// Identification
	localparam logic [15:0] MCO_TYPE    = 16'hDD55;
	localparam logic [15:0] MCO_VERSION = 16'h002E;

	//////////////////////////////////////////////////////////////////////
	// Timing, all derived from the master clock

	localparam logic [31:0] CLK_MASTER_FREQ = 32'd100_000_000;
	localparam logic [31:0] INDEX_TICK_DIV  = CLK_MASTER_FREQ / 32'd100_000;	// 10 us
	localparam logic [31:0] STEP_TICK_DIV   = CLK_MASTER_FREQ / 32'd16_000;	// 16 kHz

	localparam int SRAM_AW    = 19;
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

	typedef logic [SRAM_AW-1:0] sram_addr_t;

	// Drive control register as the host writes it, active high
	typedef struct packed {
		logic       side;
		logic       motor;
		logic [3:0] drvsel;
		logic       in_use;
		logic       density;
	} drive_ctl_t;

	// Step command, MSB is direction (0 = outward toward track 0)
	typedef struct packed {
		logic       dir;
		logic [6:0] count;
	} step_cmd_t;

	// One data bus byte, decoded per target register
	typedef union packed {
		logic [7:0] raw;
		drive_ctl_t drive;
		step_cmd_t  step;
	} host_byte_u;

	// Drive outputs, same bit layout as drive_ctl_t but active low
	typedef struct packed {
		logic       side_n;
		logic       motor_n;
		logic [3:0] drvsel_n;
		logic       inuse_n;
		logic       dens_n;
	} fd_ctl_t;

	typedef struct packed {
		logic we_n;
		logic oe_n;
		logic ce_n;
	} sram_bus_t;

	// Address counter strobes, one cycle each
	typedef struct packed {
		logic addr_upper;
		logic addr_high;
		logic addr_low;
		logic data_read_done;
	} bus_wr_t;

endpackage

/* fdc_sram_addr.sv */
`timescale 1ns/1ps

module fdc_sram_addr (
	input  logic                CLK_MASTER,
	input  logic                rst_n,
	input  fdc_pkg::bus_wr_t    bus_wr,
	input  logic [7:0]          load_data,
	input  logic                inc_write,
	output fdc_pkg::sram_addr_t addr
);
	import fdc_pkg::*;

	logic any_load;
	logic inc_any;

	assign any_load = bus_wr.addr_low || bus_wr.addr_high || bus_wr.addr_upper;
	assign inc_any  = inc_write || bus_wr.data_read_done;	// Writer or host read

	//////////////////////////////////////////////////////////////////////
	// Address counter, byte loads win over increments

	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			addr <= '0;
		end else if (any_load) begin
			if (bus_wr.addr_low)
				addr[7:0] <= load_data;
			if (bus_wr.addr_high)
				addr[15:8] <= load_data;
			if (bus_wr.addr_upper)
				addr[SRAM_AW-1:16] <= load_data[SRAM_AW-17:0];	// Top 3 bits only
		end else if (inc_any) begin
			addr <= addr + 1'b1;		// Wraps at top of SRAM
		end
	end

endmodule

/* fdc_sram_writer.sv */
`timescale 1ns/1ps

module fdc_sram_writer (
	input  logic               CLK_MASTER,
	input  logic               rst_n,
	input  logic               push,
	input  logic [7:0]         push_data,
	output logic [7:0]         sram_dq_out,
	output fdc_pkg::sram_bus_t sram_ctl,
	output logic               inc,
	output logic               fifo_empty,
	output logic               fifo_full
);
	import fdc_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,		// Outputs enabled, waiting for data
		S_OEIA,		// OE off, pop head of FIFO
		S_WRITE,	// WE low
		S_WEND,		// WE back high, data still driven
		S_INC		// Bump address
	} mwc_state_t;

	mwc_state_t            state;
	logic [7:0]            mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr, rd_ptr;
	logic [FIFO_PTR_W:0]   count;
	logic                  push_ok, pop;
	logic [7:0]            dq_q;

	//////////////////////////////////////////////////////////////////////
	// Write FIFO

	assign fifo_empty = (count == '0);
	assign fifo_full  = (count == (FIFO_PTR_W+1)'(FIFO_DEPTH));
	assign push_ok    = push && !fifo_full;	// Full FIFO drops the byte
	assign pop        = (state == S_OEIA);

	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok) wr_ptr <= wr_ptr + 1'b1;
			if (pop)     rd_ptr <= rd_ptr + 1'b1;
			case ({push_ok, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK_MASTER) begin
		if (push_ok) mem[wr_ptr] <= push_data;
		if (pop)     dq_q <= mem[rd_ptr];		// Held for the whole write
	end

	//////////////////////////////////////////////////////////////////////
	// Memory write controller

	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) state <= S_IDLE;
		else begin
			case (state)
				S_IDLE:  if (!fifo_empty) state <= S_OEIA;
				S_OEIA:  state <= S_WRITE;
				S_WRITE: state <= S_WEND;
				S_WEND:  state <= S_INC;
				default: state <= S_IDLE;
			endcase
		end
	end

	assign sram_ctl.ce_n = 1'b0;				// Chip kept selected
	assign sram_ctl.oe_n = (state != S_IDLE);
	assign sram_ctl.we_n = (state != S_WRITE);
	assign inc           = (state == S_INC);
	assign sram_dq_out   = dq_q;

	// SRAM outputs must already be off the cycle before WE falls
	a_oe_before_we: assert property (@(posedge CLK_MASTER) disable iff (!rst_n)
		$fell(sram_ctl.we_n) |-> $past(sram_ctl.oe_n) && sram_ctl.oe_n);

endmodule

/* fdc_stepper.sv */
`timescale 1ns/1ps

module fdc_stepper (
	input  logic               CLK_MASTER,
	input  logic               rst_n,
	input  logic [7:0]         step_rate,
	input  logic               cmd_wr,
	input  fdc_pkg::step_cmd_t cmd,
	input  logic               track0_in,
	output logic               step_n,
	output logic               dir,
	output logic               stepping,
	output logic               track0_hit
);
	import fdc_pkg::*;

	logic [15:0] tick_cnt;
	logic        tick;
	logic [7:0]  rate_cnt;
	logic        step_clk;
	logic        toggle;
	logic [6:0]  count;			// Steps left
	logic [1:0]  trk0_sync;

	//////////////////////////////////////////////////////////////////////
	// Step rate clock, period is 2*(rate+1) ticks

	assign tick   = (tick_cnt == 16'(STEP_TICK_DIV - 1));
	assign toggle = tick && (rate_cnt >= step_rate);	// Also catches a lowered rate

	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			tick_cnt <= 16'd0;
			rate_cnt <= 8'd0;
			step_clk <= 1'b0;
		end else begin
			tick_cnt <= tick ? 16'd0 : tick_cnt + 16'd1;
			if (toggle) begin
				rate_cnt <= 8'd0;
				step_clk <= ~step_clk;
			end else if (tick) begin
				rate_cnt <= rate_cnt + 8'd1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Step engine

	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			count      <= 7'd0;
			dir        <= 1'b0;
			step_n     <= 1'b1;
			track0_hit <= 1'b0;
			trk0_sync  <= 2'b00;
		end else begin
			trk0_sync <= {trk0_sync[0], track0_in};
			if (cmd_wr && !stepping) begin		// Busy engine drops the command
				dir        <= cmd.dir;
				count      <= cmd.count;
				track0_hit <= 1'b0;
			end else if (toggle && !step_clk && count != 7'd0) begin
				// Rising half of step clock starts a step
				if (!dir && trk0_sync[1]) begin
					count      <= 7'd0;	// Head at track 0, stop outward seek
					track0_hit <= 1'b1;
				end else begin
					step_n <= 1'b0;
					count  <= count - 7'd1;
				end
			end
			if (toggle && step_clk) step_n <= 1'b1;	// End of low half
		end
	end

	// Busy until the last pulse has finished
	assign stepping = (count != 7'd0) || !step_n;

	// Direction held for the whole step pulse
	a_dir_stable: assert property (@(posedge CLK_MASTER) disable iff (!rst_n)
		!step_n |-> $stable(dir));

endmodule

/* fdc_top.sv */
`timescale 1ns/1ps

module fdc_top (
	input  logic                CLK_MASTER,
	input  logic                rst_n,
	input  logic [7:0]          pmd_in,
	input  logic                pmalh,
	input  logic                pmall,
	input  logic                pmrd,
	input  logic                pmwr,
	input  logic                fd_index_in,
	input  logic                fd_track0_in,
	input  logic                fd_wrprot_in,
	input  logic                fd_rdy_in,
	input  logic                fd_dens_in,
	input  logic [7:0]          sram_dq_in,
	output logic [7:0]          pmd_out,
	output logic                pmd_oe,
	output logic                fd_dens_out,
	output logic                fd_inuse,
	output logic [3:0]          fd_drvsel,
	output logic                fd_motor,
	output logic                fd_side,
	output logic                fd_step,
	output logic                fd_dir,
	output fdc_pkg::sram_addr_t sram_a,
	output logic [7:0]          sram_dq_out,
	output logic                sram_we_n,
	output logic                sram_oe_n,
	output logic                sram_ce_n
);
	import fdc_pkg::*;

	fd_ctl_t    fd_ctl;
	sram_bus_t  sram_ctl;
	bus_wr_t    bus_wr;
	host_byte_u wr_data;
	logic [7:0] status1, status2;
	logic [7:0] step_rate, index_hi, index_lo;
	logic       step_cmd_wr, fifo_push, index_hi_rd, inc_write;
	logic       fifo_empty, fifo_full, new_meas, stepping, track0_hit;

	// Bit 0 tells the host the FIFO is still draining
	assign status1 = {4'b0000, track0_hit, new_meas, stepping, ~fifo_empty};
	assign status2 = {fd_index_in, fd_track0_in, fd_wrprot_in, fd_rdy_in,
		fd_dens_in, stepping, 1'b0, fifo_full};

	fdc_host_regs u_host_regs (
		.CLK_MASTER (CLK_MASTER), .rst_n (rst_n),
		.pmd_in (pmd_in), .pmalh (pmalh), .pmall (pmall), .pmrd (pmrd), .pmwr (pmwr),
		.status1 (status1), .status2 (status2), .sram_addr (sram_a),
		.sram_dq_in (sram_dq_in), .index_hi (index_hi), .index_lo (index_lo),
		.pmd_out (pmd_out), .pmd_oe (pmd_oe), .fd_ctl (fd_ctl), .step_rate (step_rate),
		.step_cmd_wr (step_cmd_wr), .fifo_push (fifo_push), .bus_wr (bus_wr),
		.wr_data (wr_data), .index_hi_rd (index_hi_rd)
	);

	fdc_sram_writer u_sram_writer (
		.CLK_MASTER (CLK_MASTER), .rst_n (rst_n),
		.push (fifo_push), .push_data (wr_data.raw),
		.sram_dq_out (sram_dq_out), .sram_ctl (sram_ctl), .inc (inc_write),
		.fifo_empty (fifo_empty), .fifo_full (fifo_full)
	);

	fdc_sram_addr u_sram_addr (
		.CLK_MASTER (CLK_MASTER), .rst_n (rst_n),
		.bus_wr (bus_wr), .load_data (wr_data.raw), .inc_write (inc_write),
		.addr (sram_a)
	);

	fdc_index_timer u_index_timer (
		.CLK_MASTER (CLK_MASTER), .rst_n (rst_n),
		.index_in (fd_index_in), .hi_read (index_hi_rd),
		.index_hi (index_hi), .index_lo (index_lo), .new_meas (new_meas)
	);

	fdc_stepper u_stepper (
		.CLK_MASTER (CLK_MASTER), .rst_n (rst_n),
		.step_rate (step_rate), .cmd_wr (step_cmd_wr), .cmd (wr_data.step),
		.track0_in (fd_track0_in),
		.step_n (fd_step), .dir (fd_dir), .stepping (stepping), .track0_hit (track0_hit)
	);

	// Drive and SRAM pins
	assign fd_dens_out = fd_ctl.dens_n;
	assign fd_inuse    = fd_ctl.inuse_n;
	assign fd_drvsel   = fd_ctl.drvsel_n;
	assign fd_motor    = fd_ctl.motor_n;
	assign fd_side     = fd_ctl.side_n;
	assign sram_we_n   = sram_ctl.we_n;
	assign sram_oe_n   = sram_ctl.oe_n;
	assign sram_ce_n   = sram_ctl.ce_n;

endmodule

/* files.f */
fdc_pkg.sv
fdc_host_regs.sv
fdc_sram_writer.sv
fdc_sram_addr.sv
fdc_index_timer.sv
fdc_stepper.sv
fdc_top.sv
tb_fdc_checker.sv
tb_fdc.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_fdc -f files.f -o tb_fdc_sim

out=$(./obj_dir/tb_fdc_sim)
echo "$out"

echo "$out" | grep -q "ALL CHECKS PASSED"

/* tb_fdc.sv */
`timescale 1ns/1ps

module tb_fdc;
	import fdc_pkg::*;

	localparam int    N_SCRATCH = 8;
	localparam int    N_BURST   = 4;
	localparam int    N_IDX     = 4;
	localparam int    N_STEP    = 6;
	// Worst case cycles per test, step test dominates (7 steps of 4 ticks each)
	localparam longint RUN_CYCLES = longint'(N_STEP) * 8 * 4 * 6250
		+ longint'(N_IDX + 1) * 61000 + 100000;
	localparam longint WATCHDOG_NS = RUN_CYCLES * 20 * 2;	// Twice for margin

	logic        CLK_MASTER, rst_n;
	logic [7:0]  pmd_in, pmd_out, sram_dq_in, sram_dq_out;
	logic        pmalh, pmall, pmrd, pmwr, pmd_oe;
	logic        fd_index_in, fd_track0_in, fd_wrprot_in, fd_rdy_in, fd_dens_in;
	logic        fd_dens_out, fd_inuse, fd_motor, fd_side, fd_step, fd_dir;
	logic [3:0]  fd_drvsel;
	logic [18:0] sram_a;
	logic        sram_we_n, sram_oe_n, sram_ce_n;
	logic [7:0]  sram_mem [0:(1<<19)-1];	// External SRAM model
	int          errors, checks, tb_errors;
	integer      seed;
	logic [31:0] rnd;
	logic [7:0]  rd_val;
	logic [18:0] burst_start;
	int          burst_len, period;

	initial begin
		CLK_MASTER = 1'b0;
		forever #10 CLK_MASTER = ~CLK_MASTER;
	end

	fdc_top u_fdc_top (.*);

	tb_fdc_checker u_checker (
		.CLK_MASTER (CLK_MASTER), .rst_n (rst_n), .pmd_in (pmd_in),
		.pmalh (pmalh), .pmall (pmall), .pmrd (pmrd), .pmwr (pmwr), .pmd_out (pmd_out),
		.pmd_oe (pmd_oe),
		.fd_index_in (fd_index_in), .fd_track0_in (fd_track0_in),
		.fd_pins ({fd_side, fd_motor, fd_drvsel, fd_inuse, fd_dens_out}),
		.fd_step (fd_step), .fd_dir (fd_dir), .sram_a (sram_a),
		.sram_dq_out (sram_dq_out), .sram_we_n (sram_we_n), .sram_oe_n (sram_oe_n),
		.sram_ce_n (sram_ce_n),
		.errors (errors), .checks (checks)
	);

	//////////////////////////////////////////////////////////////////////
	// SRAM model, fill mixes every address bit

	initial begin
		for (int i = 0; i < (1 << 19); i++)
			sram_mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'(i >> 16) ^ 8'h5A;
	end

	always @(posedge sram_we_n) begin
		if (rst_n) sram_mem[sram_a] <= sram_dq_out;	// Write at end of WE pulse
	end
	assign sram_dq_in = sram_mem[sram_a];

	//////////////////////////////////////////////////////////////////////
	// Host bus tasks

	task automatic cycles(input int n);
		repeat (n) begin
			@(posedge CLK_MASTER);
			#2;
		end
	endtask

	task automatic set_addr(input logic [7:0] a);
		pmd_in = 8'h00;		// Page 0
		pmalh  = 1'b1;
		cycles(3);
		pmalh  = 1'b0;
		pmd_in = a;
		pmall  = 1'b1;
		cycles(3);
		pmall  = 1'b0;
		cycles(3);
	endtask

	task automatic write_again(input logic [7:0] d);
		pmd_in = d;
		pmwr   = 1'b1;
		cycles(3);
		pmwr   = 1'b0;
		cycles(3);
	endtask

	task automatic read_again(output logic [7:0] d);
		pmrd = 1'b1;
		cycles(2);
		d    = pmd_out;	// Mid strobe
		cycles(1);
		pmrd = 1'b0;
		cycles(3);
	endtask

	task automatic bus_write(input logic [7:0] a, input logic [7:0] d);
		set_addr(a);
		write_again(d);
	endtask

	task automatic bus_read(input logic [7:0] a, output logic [7:0] d);
		set_addr(a);
		read_again(d);
	endtask

	// Poll one STATUS1 bit until it clears
	task automatic poll_clear(input int bit_no, input int limit, input string what);
		logic [7:0] s;
		int         n;
		n = 0;
		set_addr(REG_STATUS1);
		read_again(s);
		while (s[bit_no] && n < limit) begin
			read_again(s);
			n++;
		end
		if (s[bit_no]) begin
			tb_errors++;
			$display("%s did not finish at %0t", what, $time);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		seed = 32'hcba1_5ad1;
		tb_errors = 0;
		rst_n = 1'b0;
		{pmd_in, pmalh, pmall, pmrd, pmwr} = '0;
		{fd_index_in, fd_track0_in, fd_wrprot_in, fd_rdy_in, fd_dens_in} = '0;
		cycles(3);
		rst_n = 1'b1;
		cycles(3);

		// Scratchpad, inverse and constants
		repeat (N_SCRATCH) begin
			rnd = $random(seed);
			bus_write(REG_SCRATCH, rnd[7:0]);
			bus_read(REG_SCRATCH, rd_val);
			bus_read(REG_SCRATCH_INV, rd_val);
		end
		for (int a = 4; a < 8; a++) bus_read(8'(a), rd_val);
		bus_read(REG_FIXED_55, rd_val);
		bus_read(REG_FIXED_AA, rd_val);
		bus_read(8'h20, rd_val);		// Unused, reads zero

		// Drive control, pins checked on the following read
		repeat (N_SCRATCH) begin
			rnd = $random(seed);
			bus_write(REG_DRIVE_CTL, rnd[7:0]);
			bus_read(REG_FIXED_55, rd_val);
		end

		// SRAM bursts from random start addresses
		repeat (N_BURST) begin
			rnd = $random(seed);
			burst_start = rnd[18:0];
			burst_len   = 1 + int'(rnd[23:20]);
			bus_write(REG_ADDR_LOW, burst_start[7:0]);
			bus_write(REG_ADDR_HIGH, burst_start[15:8]);
			bus_write(REG_ADDR_UPPER, {5'b00000, burst_start[18:16]});
			set_addr(REG_SRAM_DATA);
			for (int i = 0; i < burst_len; i++) begin
				rnd = $random(seed);
				write_again(rnd[7:0]);
			end
			poll_clear(0, 50, "FIFO drain");
			bus_read(REG_ADDR_LOW, rd_val);
			bus_read(REG_ADDR_HIGH, rd_val);
			bus_read(REG_ADDR_UPPER, rd_val);
		end

		// Read the last burst back through the data register
		bus_write(REG_ADDR_LOW, burst_start[7:0]);
		bus_write(REG_ADDR_HIGH, burst_start[15:8]);
		bus_write(REG_ADDR_UPPER, {5'b00000, burst_start[18:16]});
		set_addr(REG_SRAM_DATA);
		for (int i = 0; i < burst_len; i++) read_again(rd_val);
		bus_read(REG_ADDR_LOW, rd_val);
		bus_read(REG_ADDR_UPPER, rd_val);

		// Index periods, first edge only arms the measurement
		for (int k = 0; k <= N_IDX; k++) begin
			rnd = $random(seed);
			period = 20 + int'(rnd[15:0] % 16'd41);
			fd_index_in = 1'b1;
			cycles(50);
			fd_index_in = 1'b0;
			bus_read(REG_STATUS1, rd_val);	// New flag up
			bus_read(REG_INDEX_HI, rd_val);
			bus_read(REG_INDEX_LO, rd_val);
			bus_read(REG_STATUS1, rd_val);	// Cleared by the high read
			cycles(period * 1000 - 100);
		end

		// Stepper, first command forced onto track 0
		rnd = $random(seed);
		bus_write(REG_STEP_RATE, {7'd0, rnd[0]});
		bus_read(REG_STEP_RATE, rd_val);
		for (int k = 0; k < N_STEP; k++) begin
			rnd = $random(seed);
			if (k == 0) rnd[9:7] = 3'b100;
			fd_track0_in = (rnd[9:8] == 2'b10);
			bus_write(REG_STEP_CMD, {rnd[7], 4'b0000, rnd[2:0] | {2'b00, k == 0}});
			poll_clear(1, 40000, "Step command");
			fd_track0_in = 1'b0;
		end

		cycles(10);
		$display("checks %0d, checker errors %0d, testbench errors %0d",
			checks, errors, tb_errors);
		if (errors == 0 && tb_errors == 0 && checks > 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Hang guard
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog timeout, the run did not complete in time");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* tb_fdc_checker.sv */
`timescale 1ns/1ps

module tb_fdc_checker (
	input  logic        CLK_MASTER,
	input  logic        rst_n,
	input  logic [7:0]  pmd_in,
	input  logic        pmalh,
	input  logic        pmall,
	input  logic        pmrd,
	input  logic        pmwr,
	input  logic [7:0]  pmd_out,
	input  logic        pmd_oe,
	input  logic        fd_index_in,
	input  logic        fd_track0_in,
	input  logic [7:0]  fd_pins,		// side, motor, drvsel, inuse, dens
	input  logic        fd_step,
	input  logic        fd_dir,
	input  logic [18:0] sram_a,
	input  logic [7:0]  sram_dq_out,
	input  logic        sram_we_n,
	input  logic        sram_oe_n,
	input  logic        sram_ce_n,
	output int          errors,
	output int          checks
);
	import fdc_pkg::*;

	logic [7:0]  addr_hi, addr_lo;		// Model of the address latch
	logic        pmwr_q, pmrd_q, we_q, idx_q, step_q;
	logic [7:0]  scratch_m, drive_m, rate_m, lo_m;
	logic [18:0] addr_m;
	logic [7:0]  fifo_q [$];			// Bytes waiting for the SRAM
	logic [7:0]  mem_m [logic [18:0]];	// Bytes written so far
	longint      cyc, last_edge;
	int          edges, rd_len, step_cnt, exp_steps;
	logic [15:0] period_m;
	logic        idx_valid, new_m, exp_dir, exp_hit, step_pending;

	task automatic compare(input logic [7:0] got, input logic [7:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s read %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Host reads, checked in the second strobe cycle

	task automatic check_read();
		logic [7:0] d;
		d = pmd_out;
		compare(fd_pins, ~drive_m, "drive pins");	// Active low copy
		if (addr_hi != 8'h00) compare(d, 8'h00, "unused page");
		else case (addr_lo)
			REG_ADDR_LOW:    compare(d, addr_m[7:0], "address low");
			REG_ADDR_HIGH:   compare(d, addr_m[15:8], "address high");
			REG_ADDR_UPPER:  compare(d, {5'b00000, addr_m[18:16]}, "address upper");
			REG_SRAM_DATA: begin
				if (mem_m.exists(addr_m)) compare(d, mem_m[addr_m], "SRAM data");
				else begin
					errors++;
					$display("Read of an SRAM address never written at %0t", $time);
				end
			end
			8'h04: compare(d, 8'h55, "type low");
			8'h05: compare(d, 8'hDD, "type high");
			8'h06: compare(d, 8'h2E, "version low");
			8'h07: compare(d, 8'h00, "version high");
			REG_STATUS1: begin
				compare({7'd0, d[2]}, {7'd0, new_m}, "new flag");
				if (step_pending && !d[1]) begin	// Stepping just ended
					compare(8'(step_cnt), 8'(exp_steps), "step pulses");
					compare({7'd0, d[3]}, {7'd0, exp_hit}, "track0 hit");
					compare({7'd0, fd_dir}, {7'd0, exp_dir}, "dir level");
					step_pending = 1'b0;
				end
			end
			REG_STATUS2: ;						// Raw pins, not predicted
			REG_SCRATCH:     compare(d, scratch_m, "scratch");
			REG_SCRATCH_INV: compare(d, ~scratch_m, "scratch inverse");
			REG_FIXED_55:    compare(d, 8'h55, "fixed 55");
			REG_FIXED_AA:    compare(d, 8'hAA, "fixed AA");
			REG_STEP_RATE:   compare(d, rate_m, "step rate");
			REG_INDEX_HI: begin
				if (idx_valid) compare(d, period_m[15:8], "index high");
				lo_m  = period_m[7:0];
				new_m = 1'b0;
			end
			REG_INDEX_LO: begin
				checks++;
				if (idx_valid && (int'(d) > int'(lo_m) + 1 || int'(d) + 1 < int'(lo_m))) begin
					errors++;
					$display("MISMATCH at %0t: index low read %02h, expected %02h +-1",
						$time, d, lo_m);
				end
			end
			default: compare(d, 8'h00, "unused address");
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// Host writes, taken when pmwr is first seen high

	task automatic apply_write();
		if (addr_hi != 8'h00) return;
		case (addr_lo)
			REG_ADDR_LOW:   addr_m[7:0]   = pmd_in;
			REG_ADDR_HIGH:  addr_m[15:8]  = pmd_in;
			REG_ADDR_UPPER: addr_m[18:16] = pmd_in[2:0];
			REG_SRAM_DATA:  fifo_q.push_back(pmd_in);
			REG_DRIVE_CTL:  drive_m   = pmd_in;
			REG_STEP_RATE:  rate_m    = pmd_in;
			REG_SCRATCH:    scratch_m = pmd_in;
			REG_STEP_CMD: begin
				exp_dir      = pmd_in[7];
				exp_hit      = fd_track0_in && !pmd_in[7] && (pmd_in[6:0] != 7'd0);
				exp_steps    = exp_hit ? 0 : int'(pmd_in[6:0]);
				step_cnt     = 0;
				step_pending = 1'b1;
			end
			default: ;
		endcase
	endtask

	always @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			{addr_hi, addr_lo, scratch_m, drive_m, rate_m, lo_m} = '0;
			{pmwr_q, pmrd_q, idx_q, idx_valid, new_m, step_pending} = '0;
			{we_q, step_q} = 2'b11;
			addr_m = '0;
			fifo_q.delete();
			{cyc, last_edge, edges, rd_len, step_cnt, period_m} = '0;
			errors = 0;
			checks = 0;
		end else begin
			cyc++;
			if (pmrd) begin
				if (rd_len == 1) check_read();
				rd_len++;
			end else rd_len = 0;
			if (pmwr && !pmwr_q) apply_write();
			if (!pmrd && pmrd_q && addr_hi == 8'h00 && addr_lo == REG_SRAM_DATA)
				addr_m++;						// Host read advances the counter

			// Data bus driver follows the read strobe
			if (pmd_oe !== pmrd) begin
				errors++;
				$display("MISMATCH at %0t: pmd_oe %b, expected %b", $time, pmd_oe, pmrd);
			end
			if (sram_ce_n !== 1'b0) begin		// Chip always selected
				errors++;
				$display("MISMATCH at %0t: sram_ce_n %b, expected 0", $time, sram_ce_n);
			end

			// SRAM write ends on the rising WE
			if (!sram_we_n && !sram_oe_n) begin
				errors++;
				$display("WE and OE both low at %0t", $time);
			end
			if (!we_q && sram_we_n) begin
				if (fifo_q.size() == 0) begin
					errors++;
					$display("SRAM write with no byte queued at %0t", $time);
				end else begin
					compare(sram_dq_out, fifo_q[0], "SRAM write data");
					checks++;
					if (sram_a !== addr_m) begin
						errors++;
						$display("MISMATCH at %0t: SRAM write address %05h, expected %05h",
							$time, sram_a, addr_m);
					end
					mem_m[addr_m] = fifo_q.pop_front();
					addr_m++;
				end
			end

			// Index period in 10 us ticks
			if (fd_index_in && !idx_q) begin
				if (edges > 0) period_m = 16'((cyc - last_edge) / 1000);
				idx_valid = (edges > 0);
				last_edge = cyc;
				edges++;
				new_m = 1'b1;
			end

			if (!fd_step && step_q) begin
				step_cnt++;
				compare({7'd0, fd_dir}, {7'd0, exp_dir}, "dir at step");
			end

			if (pmalh) addr_hi = pmd_in;
			if (pmall) addr_lo = pmd_in;
			pmwr_q = pmwr;
			pmrd_q = pmrd;
			we_q   = sram_we_n;
			idx_q  = fd_index_in;
			step_q = fd_step;
		end
	end

endmodule
